//--- verilog/axi_st_pkg.sv
`default_nettype none

package axi_st_pkg;

  //////////////////////////////////////////////////
  // User stream geometry
  //////////////////////////////////////////////////

  // Payload bits per user beat
  localparam int user_data_width = 64;

  // One keep bit per data byte
  localparam int user_keep_width = user_data_width / 8;

  //////////////////////////////////////////////////
  // Link rate selection
  //////////////////////////////////////////////////

  // GEN1 is half rate with two beats on channel 0
  // GEN2 is full rate with one beat across both channels
  typedef enum logic {
    GEN1 = 1'b0,
    GEN2 = 1'b1
  } gen_mode_e;

endpackage

`default_nettype wire

//--- verilog/ll_pkg.sv
`default_nettype none

package ll_pkg;

  //////////////////////////////////////////////////
  // Link word and PHY beat layout
  //////////////////////////////////////////////////

  // Link word is data, then keep, last on top
  localparam int ll_word_width = axi_st_pkg::user_data_width +
                                 axi_st_pkg::user_keep_width + 1;

  // One PHY channel beat
  localparam int phy_width         = 40;
  localparam int phy_payload_width = 37;
  // Upper slice of the word, one pad bit short of a full payload
  localparam int phy_hi_width      = ll_word_width - phy_payload_width;

  // Overhead bits at the top of every beat
  localparam int phy_push_bit   = 39;
  localparam int phy_strobe_bit = 38;
  localparam int phy_marker_bit = 37;

  //////////////////////////////////////////////////
  // Flow control and buffering
  //////////////////////////////////////////////////

  localparam int credit_width       = 8;
  localparam int tx_fifo_depth      = 4;
  localparam int tx_fifo_addr_width = $clog2(tx_fifo_depth);
  // Extra wrap bit tells full from empty
  localparam int tx_fifo_ptr_width  = tx_fifo_addr_width + 1;

  // Per-side online sequencing
  typedef enum logic [1:0] {
    OFFLINE  = 2'd0,
    DELAYING = 2'd1,
    ONLINE   = 2'd2
  } sync_state_e;

  // Which gen1 half goes out next
  typedef enum logic {
    PH_FIRST  = 1'b0,
    PH_SECOND = 1'b1
  } beat_phase_e;

endpackage

`default_nettype wire

//--- verilog/ll_link_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ll_link_if;

  // Packed user word at the FIFO head
  logic [ll_pkg::ll_word_width-1:0] word;
  // Word offered and taken this cycle
  logic                             push;
  // Concatenator free for a new word
  logic                             link_ready;
  // One credit back from the far side
  logic                             credit_return;
  // Delayed transmit online, driven at the top
  logic                             online;

  modport tx_side (
    output word,
    output push,
    input  link_ready,
    input  credit_return,
    input  online
  );

  modport phy_side (
    input  word,
    input  push,
    output link_ready,
    output credit_return,
    input  online
  );

endinterface

`default_nettype wire

//--- verilog/ll_auto_sync.sv
`timescale 1ns/1ns
`default_nettype none

module ll_auto_sync (
  input  logic        clk_wr,
  input  logic        rst,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [15:0] delay_z_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        credit_load
);

  // Slot 0 is the transmit side, slot 1 the receive side
  logic                side_in    [2];
  logic [15:0]         side_delay [2];
  ll_pkg::sync_state_e side_state [2];
  logic [15:0]         side_count [2];

  // Credit load holdoff after tx goes online
  logic [15:0] z_count;
  logic        z_done;

  assign side_in[0]    = tx_online;
  assign side_in[1]    = rx_online;
  assign side_delay[0] = delay_x_value;
  assign side_delay[1] = delay_y_value;

  //////////////////////////////////////////////////
  // Online delay machines
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      // Losing the input drops the side straight away
      if (rst || !side_in[i]) begin
        side_state[i] <= ll_pkg::OFFLINE;
        side_count[i] <= '0;
      end else begin
        case (side_state[i])
          ll_pkg::OFFLINE: begin
            side_count[i] <= side_delay[i];
            side_state[i] <= ll_pkg::DELAYING;
          end
          ll_pkg::DELAYING: begin
            if (side_count[i] <= 16'd1)
              side_state[i] <= ll_pkg::ONLINE;
            else
              side_count[i] <= side_count[i] - 16'd1;
          end
          default: side_state[i] <= ll_pkg::ONLINE;
        endcase
      end
    end
  end

  assign tx_online_delay = (side_state[0] == ll_pkg::ONLINE);
  assign rx_online_delay = (side_state[1] == ll_pkg::ONLINE);

  //////////////////////////////////////////////////
  // Credit load, one pulse per online period
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      z_count     <= delay_z_value;
      z_done      <= 1'b0;
      credit_load <= 1'b0;
    end else begin
      credit_load <= 1'b0;
      if (!z_done) begin
        if (z_count == 16'd0) begin
          credit_load <= 1'b1;
          z_done      <= 1'b1;
        end else begin
          z_count <= z_count - 16'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ll_transmit.sv
`timescale 1ns/1ns
`default_nettype none

module ll_transmit (
  input  logic                                   clk_wr,
  input  logic                                   rst,
  input  logic [axi_st_pkg::user_data_width-1:0] user_tdata,
  input  logic [axi_st_pkg::user_keep_width-1:0] user_tkeep,
  input  logic                                   user_tlast,
  input  logic                                   user_tvalid,
  output logic                                   user_tready,
  input  logic [ll_pkg::credit_width-1:0]        init_st_credit,
  input  logic                                   credit_load,
  input  logic                                   rx_online_delay,
  ll_link_if.tx_side                             link,
  output logic [15:0]                            tx_st_debug_status
);

  // Word storage, payload only
  logic [ll_pkg::ll_word_width-1:0]     fifo_mem [ll_pkg::tx_fifo_depth];

  // Pointers carry a wrap bit above the address
  logic [ll_pkg::tx_fifo_ptr_width-1:0] wr_ptr;
  logic [ll_pkg::tx_fifo_ptr_width-1:0] rd_ptr;
  logic [ll_pkg::tx_fifo_ptr_width-1:0] fifo_count;
  logic                                 fifo_full;
  logic                                 fifo_empty;
  logic                                 wr_en;

  // Credits granted by the far side
  logic [ll_pkg::credit_width-1:0]      credit;
  logic                                 credit_add;
  logic                                 credit_avail;
  logic [ll_pkg::ll_word_width-1:0]     packed_word;

  //////////////////////////////////////////////////
  // User side
  //////////////////////////////////////////////////

  // Last on top, keep next, data at the bottom
  assign packed_word = {user_tlast, user_tkeep, user_tdata};

  assign fifo_count = wr_ptr - rd_ptr;
  assign fifo_full  = (fifo_count == ll_pkg::tx_fifo_depth);
  assign fifo_empty = (fifo_count == '0);

  // Accept only once the link is up and there is room
  assign user_tready = !fifo_full && link.online;
  assign wr_en       = user_tvalid && user_tready;

  always_ff @(posedge clk_wr) begin
    if (wr_en)
      fifo_mem[wr_ptr[ll_pkg::tx_fifo_addr_width-1:0]] <= packed_word;
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + ll_pkg::tx_fifo_ptr_width'(1);
      // Head leaves on every push
      if (link.push)
        rd_ptr <= rd_ptr + ll_pkg::tx_fifo_ptr_width'(1);
    end
  end

  //////////////////////////////////////////////////
  // Credit accounting and release
  //////////////////////////////////////////////////

  // Returns only count while rx side is up
  assign credit_add   = link.credit_return && rx_online_delay;
  assign credit_avail = (credit != '0);

  // Head word goes out when a credit and the concatenator are both free
  assign link.push = link.online && !fifo_empty && credit_avail && link.link_ready;
  assign link.word = fifo_mem[rd_ptr[ll_pkg::tx_fifo_addr_width-1:0]];

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      credit <= '0;
    end else if (credit_load) begin
      credit <= init_st_credit;
    end else begin
      case ({credit_add, link.push})
        2'b10:   credit <= credit + ll_pkg::credit_width'(1);
        2'b01:   credit <= credit - ll_pkg::credit_width'(1);
        // Return and spend in the same cycle cancel out
        default: credit <= credit;
      endcase
    end
  end

  // Occupancy high byte, credit low byte
  assign tx_st_debug_status = {
    {(16 - ll_pkg::credit_width - ll_pkg::tx_fifo_ptr_width){1'b0}},
    fifo_count,
    credit
  };

endmodule

`default_nettype wire

//--- verilog/axi_st_master_concat.sv
`timescale 1ns/1ns
`default_nettype none

module axi_st_master_concat (
  input  logic                        clk_wr,
  input  logic                        rst,
  input  logic                        m_gen2_mode,
  ll_link_if.phy_side                 link,
  output logic [ll_pkg::phy_width-1:0] tx_phy0,
  output logic [ll_pkg::phy_width-1:0] tx_phy1,
  input  logic [ll_pkg::phy_width-1:0] rx_phy0,
  // Reserved channel, nothing comes back on it yet
  input  logic [ll_pkg::phy_width-1:0] rx_phy1
);

  axi_st_pkg::gen_mode_e            gen_mode;
  ll_pkg::beat_phase_e              phase;
  // Upper half parked for the gen1 second beat
  logic [ll_pkg::phy_hi_width-1:0]  hi_hold;
  logic [ll_pkg::phy_payload_width-1:0] lo_slice;
  logic [ll_pkg::phy_payload_width-1:0] hi_slice;
  logic [ll_pkg::phy_width-1:0]     idle_beat;

  // Push, persistent strobe, marker, then payload
  function automatic logic [ll_pkg::phy_width-1:0] make_beat(
    input logic                                push_b,
    input logic                                marker_b,
    input logic [ll_pkg::phy_payload_width-1:0] payload
  );
    logic [ll_pkg::phy_width-1:0] beat;
    beat                         = '0;
    beat[ll_pkg::phy_push_bit]   = push_b;
    beat[ll_pkg::phy_strobe_bit] = 1'b1;
    beat[ll_pkg::phy_marker_bit] = marker_b;
    beat[ll_pkg::phy_payload_width-1:0] = payload;
    return beat;
  endfunction

  assign gen_mode  = axi_st_pkg::gen_mode_e'(m_gen2_mode);
  assign lo_slice  = link.word[ll_pkg::phy_payload_width-1:0];
  // One zero pad on top of the upper slice
  assign hi_slice  = {1'b0, link.word[ll_pkg::ll_word_width-1:ll_pkg::phy_payload_width]};
  assign idle_beat = make_beat(1'b0, 1'b1, '0);

  // Busy only while the gen1 upper half is pending
  assign link.link_ready = (phase == ll_pkg::PH_FIRST);

  //////////////////////////////////////////////////
  // Beat formatting
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (link.push)
      hi_hold <= link.word[ll_pkg::ll_word_width-1:ll_pkg::phy_payload_width];
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
      phase   <= ll_pkg::PH_FIRST;
    end else if (!link.online) begin
      // Quiet lines until the link is up
      tx_phy0 <= '0;
      tx_phy1 <= '0;
      phase   <= ll_pkg::PH_FIRST;
    end else if (phase == ll_pkg::PH_SECOND) begin
      tx_phy0 <= make_beat(1'b1, 1'b0, {1'b0, hi_hold});
      tx_phy1 <= idle_beat;
      phase   <= ll_pkg::PH_FIRST;
    end else if (link.push && gen_mode == axi_st_pkg::GEN2) begin
      tx_phy0 <= make_beat(1'b1, 1'b1, lo_slice);
      tx_phy1 <= make_beat(1'b1, 1'b0, hi_slice);
    end else if (link.push) begin
      // Gen1 low half now, upper half next cycle
      tx_phy0 <= make_beat(1'b1, 1'b1, lo_slice);
      tx_phy1 <= idle_beat;
      phase   <= ll_pkg::PH_SECOND;
    end else begin
      tx_phy0 <= idle_beat;
      tx_phy1 <= idle_beat;
    end
  end

  // Credit return rides on bit 0 of channel 0
  always_ff @(posedge clk_wr) begin
    if (rst)
      link.credit_return <= 1'b0;
    else
      link.credit_return <= rx_phy0[0];
  end

endmodule

`default_nettype wire

//--- verilog/axi_st_master_top.sv
`timescale 1ns/1ns
`default_nettype none

module axi_st_master_top (
  input  logic                                   clk_wr,
  input  logic                                   rst,

  // Link bring-up
  input  logic                                   tx_online,
  input  logic                                   rx_online,
  input  logic [ll_pkg::credit_width-1:0]        init_st_credit,
  input  logic                                   m_gen2_mode,
  input  logic [15:0]                            delay_x_value,
  input  logic [15:0]                            delay_y_value,
  input  logic [15:0]                            delay_z_value,

  // AXI-stream user side
  input  logic [axi_st_pkg::user_data_width-1:0] user_tdata,
  input  logic [axi_st_pkg::user_keep_width-1:0] user_tkeep,
  input  logic                                   user_tlast,
  input  logic                                   user_tvalid,
  output logic                                   user_tready,

  // PHY channels
  output logic [ll_pkg::phy_width-1:0]           tx_phy0,
  input  logic [ll_pkg::phy_width-1:0]           rx_phy0,
  output logic [ll_pkg::phy_width-1:0]           tx_phy1,
  input  logic [ll_pkg::phy_width-1:0]           rx_phy1,

  output logic [15:0]                            tx_st_debug_status
);

  logic tx_online_delay;
  logic rx_online_delay;
  logic credit_load;

  ll_link_if link_i ();

  assign link_i.online = tx_online_delay;

  //////////////////////////////////////////////////
  // Bring-up, buffering, PHY formatting
  //////////////////////////////////////////////////

  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .credit_load     (credit_load)
  );

  ll_transmit ll_transmit_i (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .user_tdata         (user_tdata),
    .user_tkeep         (user_tkeep),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .init_st_credit     (init_st_credit),
    .credit_load        (credit_load),
    .rx_online_delay    (rx_online_delay),
    .link               (link_i.tx_side),
    .tx_st_debug_status (tx_st_debug_status)
  );

  axi_st_master_concat axi_st_master_concat_i (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .m_gen2_mode (m_gen2_mode),
    .link        (link_i.phy_side),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .rx_phy0     (rx_phy0),
    .rx_phy1     (rx_phy1)
  );

endmodule

`default_nettype wire

//--- sim/axi_st_master_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module axi_st_master_assertions (
  input logic                            clk_wr,
  input logic                            rst,
  input logic                            m_gen2_mode,
  input logic                            push,
  input logic                            link_ready,
  input logic [ll_pkg::credit_width-1:0] credit,
  input ll_pkg::sync_state_e             tx_state,
  input logic [ll_pkg::phy_width-1:0]    tx_phy0,
  input logic [ll_pkg::phy_width-1:0]    tx_phy1
);

  // Running count of failed checks
  int fail_count = 0;

  //////////////////////////////////////////////////
  // Link handshake
  //////////////////////////////////////////////////

  // A data beat on the PHY was paid for with a credit
  push_needs_credit: assert property (@(posedge clk_wr) disable iff (rst)
    (tx_phy0[ll_pkg::phy_push_bit] && tx_phy0[ll_pkg::phy_marker_bit]) |->
      ($past(credit) != '0))
    else begin
      $error("PHY data beat sent with zero credit");
      fail_count++;
    end

  // Gen1 upper half blocks the next word
  second_beat_busy: assert property (@(posedge clk_wr) disable iff (rst)
    (push && !m_gen2_mode) |=> !link_ready)
    else begin
      $error("link_ready high during gen1 second beat");
      fail_count++;
    end

  //////////////////////////////////////////////////
  // PHY lines
  //////////////////////////////////////////////////

  // Strobe persists on both channels once online
  strobe_when_online: assert property (@(posedge clk_wr) disable iff (rst)
    (tx_state == ll_pkg::ONLINE) |=>
      (tx_phy0[ll_pkg::phy_strobe_bit] && tx_phy1[ll_pkg::phy_strobe_bit]))
    else begin
      $error("strobe low while online");
      fail_count++;
    end

  // Offline means no data beats at all
  quiet_when_offline: assert property (@(posedge clk_wr) disable iff (rst)
    (tx_state != ll_pkg::ONLINE) |=>
      (!tx_phy0[ll_pkg::phy_push_bit] && !tx_phy1[ll_pkg::phy_push_bit]))
    else begin
      $error("PHY push while offline");
      fail_count++;
    end

endmodule

bind axi_st_master_top axi_st_master_assertions assertions_i (
  .clk_wr      (clk_wr),
  .rst         (rst),
  .m_gen2_mode (m_gen2_mode),
  .push        (link_i.push),
  .link_ready  (link_i.link_ready),
  .credit      (ll_transmit_i.credit),
  .tx_state    (ll_auto_sync_i.side_state[0]),
  .tx_phy0     (tx_phy0),
  .tx_phy1     (tx_phy1)
);

`default_nettype wire

//--- sim/tb_axi_st_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_st_master;

  localparam int word_w = ll_pkg::ll_word_width;
  localparam int beat_w = ll_pkg::phy_width;

  logic                                   clk_wr;
  logic                                   rst;
  logic                                   tx_online;
  logic                                   rx_online;
  logic [ll_pkg::credit_width-1:0]        init_st_credit;
  logic                                   m_gen2_mode;
  logic [15:0]                            delay_x_value;
  logic [15:0]                            delay_y_value;
  logic [15:0]                            delay_z_value;
  logic [axi_st_pkg::user_data_width-1:0] user_tdata;
  logic [axi_st_pkg::user_keep_width-1:0] user_tkeep;
  logic                                   user_tlast;
  logic                                   user_tvalid;
  logic                                   user_tready;
  logic [beat_w-1:0]                      tx_phy0;
  logic [beat_w-1:0]                      rx_phy0;
  logic [beat_w-1:0]                      tx_phy1;
  logic [beat_w-1:0]                      rx_phy1;
  logic [15:0]                            tx_st_debug_status;

  integer            seed;
  // Accepted words still owed on the PHY in arrival order
  logic [word_w-1:0] exp_q [$];
  logic [word_w-1:0] hold_word;
  logic [word_w-1:0] head_word;
  logic              pending_hi;
  int                words_in;
  int                words_out;
  int                err_count;
  int                check_count;
  int                tests_ok;
  int                base_err;
  int                out_base;

  axi_st_master_top dut0 (.*);

  always #50 clk_wr = ~clk_wr;

  // Expected data beat
  // Upper selects the high slice and its pad bit
  function automatic logic [beat_w-1:0] ref_beat(
    input logic [word_w-1:0] word,
    input bit                upper
  );
    logic [beat_w-1:0] beat;
    beat[39] = 1'b1;
    beat[38] = 1'b1;
    beat[37] = !upper;
    beat[36:0] = upper ? {1'b0, word[72:37]} : word[36:0];
    return beat;
  endfunction

  task automatic check_value(input bit ok, input string msg);
    check_count++;
    assert (ok) else begin
      $display("Error at %0t ns: %s", $time, msg);
      err_count++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    if (err_count == base_err) begin
      tests_ok++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d errors", num, name, err_count - base_err);
    end
  endtask

  //////////////////////////////////////////////////
  // Beat checker
  //////////////////////////////////////////////////

  always @(negedge clk_wr) begin
    if (!rst) begin
      if (pending_hi) begin
        // Gen1 upper half must follow right away
        check_value(tx_phy0 == ref_beat(hold_word, 1'b1),
                    $sformatf("gen1 high beat %h, expected %h", tx_phy0, ref_beat(hold_word, 1'b1)));
        check_value(!tx_phy1[39], "push on phy1 in gen1 mode");
        pending_hi = 1'b0;
        words_out++;
      end else if (tx_phy0[39]) begin
        if (exp_q.size() == 0) begin
          $display("PHY beat with push set while no user word was outstanding");
          err_count++;
        end else begin
          head_word = exp_q.pop_front();
          check_value(tx_phy0 == ref_beat(head_word, 1'b0),
                      $sformatf("phy0 beat %h, expected %h", tx_phy0, ref_beat(head_word, 1'b0)));
          if (m_gen2_mode) begin
            check_value(tx_phy1 == ref_beat(head_word, 1'b1),
                        $sformatf("phy1 beat %h, expected %h", tx_phy1, ref_beat(head_word, 1'b1)));
            words_out++;
          end else begin
            hold_word  = head_word;
            pending_hi = 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Starts and ends just after a rising edge
  task automatic send_word();
    logic [word_w-1:0] w;
    int                gap;
    int                wait_cnt;
    bit                taken;
    gap = $random(seed) & 3;
    repeat (gap) begin
      @(posedge clk_wr);
      #5;
    end
    user_tdata  = {$random(seed), $random(seed)};
    user_tkeep  = $random(seed);
    user_tlast  = $random(seed);
    user_tvalid = 1'b1;
    w           = {user_tlast, user_tkeep, user_tdata};
    taken       = 1'b0;
    wait_cnt    = 0;
    while (!taken && wait_cnt < 300) begin
      @(negedge clk_wr);
      if (user_tready) begin
        taken = 1'b1;
        exp_q.push_back(w);
        words_in++;
      end else begin
        wait_cnt++;
      end
      @(posedge clk_wr);
      #5;
    end
    user_tvalid = 1'b0;
    if (!taken) begin
      $display("User word %0d was never accepted before the timeout", words_in);
      err_count++;
    end
  endtask

  task automatic send_words(input int n);
    @(posedge clk_wr);
    #5;
    repeat (n) send_word();
  endtask

  // One-cycle pulses on rx_phy0 bit 0
  task automatic return_credits(input int n);
    repeat (n) begin
      @(posedge clk_wr);
      #5 rx_phy0 = 40'd1;
      @(posedge clk_wr);
      #5 rx_phy0 = '0;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || pending_hi) && n < 1000) begin
      @(negedge clk_wr);
      n++;
    end
    if (exp_q.size() != 0 || pending_hi) begin
      $display("Timed out with %0d words still missing on the PHY", exp_q.size());
      err_count++;
    end
  endtask

  // Drops tx online, sets mode and credit, then waits for the delayed online
  task automatic bring_online(input logic gen2, input logic [7:0] credit, input bit check_quiet);
    int i;
    int n;
    @(posedge clk_wr);
    #5 tx_online = 1'b0;
    repeat (3) @(posedge clk_wr);
    #5;
    m_gen2_mode    = gen2;
    init_st_credit = credit;
    tx_online      = 1'b1;
    if (check_quiet) begin
      for (i = 0; i < delay_x_value; i++) begin
        @(negedge clk_wr);
        check_value(!user_tready && !tx_phy0[39] && !tx_phy1[39],
                    $sformatf("link active %0d cycles into the online delay", i));
      end
    end
    n = 0;
    while (!user_tready && n < 200) begin
      @(negedge clk_wr);
      n++;
    end
    if (!user_tready) begin
      $display("Link never came online after tx_online rose");
      err_count++;
    end
    // Credit counter loads a few cycles later
    n = 0;
    while (tx_st_debug_status[7:0] != credit && n < 200) begin
      @(negedge clk_wr);
      n++;
    end
    if (tx_st_debug_status[7:0] != credit) begin
      $display("Initial credit was never loaded");
      err_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed = 38;
    clk_wr = 1'b0;
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_st_credit = '0;
    m_gen2_mode = 1'b1;
    delay_x_value = 16'd10;
    delay_y_value = 16'd6;
    delay_z_value = 16'd4;
    user_tdata = '0;
    user_tkeep = '0;
    user_tlast = 1'b0;
    user_tvalid = 1'b0;
    rx_phy0 = '0;
    rx_phy1 = '0;
    pending_hi = 1'b0;
    words_in = 0;
    words_out = 0;
    err_count = 0;
    check_count = 0;
    tests_ok = 0;
    repeat (16) @(posedge clk_wr);
    #5 rst = 1'b0;
    rx_online = 1'b1;

    // Quiet before and during the online delay
    base_err = err_count;
    repeat (4) begin
      @(negedge clk_wr);
      check_value(!user_tready && !tx_phy0[39], "link active before tx_online");
    end
    bring_online(axi_st_pkg::GEN2, 8'd200, 1'b1);
    report_test(1, "offline quiet");

    base_err = err_count;
    send_words(40);
    wait_drained();
    report_test(2, "gen2 stream");

    base_err = err_count;
    bring_online(axi_st_pkg::GEN1, 8'd200, 1'b0);
    send_words(40);
    wait_drained();
    report_test(3, "gen1 stream");

    // Three credits, seven words, then five returns
    base_err = err_count;
    bring_online(axi_st_pkg::GEN2, 8'd3, 1'b0);
    out_base = words_out;
    send_words(7);
    repeat (10) @(negedge clk_wr);
    check_value(words_out - out_base == 3,
                $sformatf("%0d words left on 3 credits", words_out - out_base));
    check_value(!user_tready, "user_tready high with the FIFO full");
    return_credits(5);
    wait_drained();
    check_value(words_out - out_base == 7,
                $sformatf("%0d of 7 words left after returns", words_out - out_base));
    report_test(4, "credit limit");

    base_err = err_count;
    repeat (3) @(negedge clk_wr);
    check_value(tx_st_debug_status[7:0] == 8'(3 + 5 - (words_out - out_base)),
                $sformatf("debug credit %0d", tx_st_debug_status[7:0]));
    check_value(tx_st_debug_status[15:8] == 8'(words_in - words_out),
                $sformatf("debug occupancy %0d", tx_st_debug_status[15:8]));
    report_test(5, "debug status");

    err_count += dut0.assertions_i.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d of 5 tests ok",
             check_count, err_count, tests_ok);
    if (err_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/axi_st_pkg.sv
verilog/ll_pkg.sv
verilog/ll_link_if.sv
verilog/ll_auto_sync.sv
verilog/ll_transmit.sv
verilog/axi_st_master_concat.sv
verilog/axi_st_master_top.sv
sim/axi_st_master_assertions.sv
sim/tb_axi_st_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_axi_st_master \
  -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Test completed successfully" "$log_file"; then
  exit 0
fi
echo "Pass line not found in $log_file"
exit 1
